//--- src/mem_types_pkg.sv
`default_nettype none

package mem_types_pkg;

    localparam int DATA_W     = 32;                        // Core data width
    localparam int DATA_LANES = DATA_W / 8;                // Byte lanes per word

    // RAM window, in words
    localparam int DATA_MEM_WORDS = 256;
    localparam int DATA_MEM_AW    = $clog2(DATA_MEM_WORDS);

    typedef logic [DATA_W-1:0]     data_t;                 // One data word
    typedef logic [DATA_W-1:0]     data_addr_t;            // Byte address
    typedef logic [DATA_LANES-1:0] byte_mask_t;            // Write enable per lane

    // Load/store size as the core encodes it
    typedef enum logic [1:0] {
        ACCESS_BYTE = 2'b00,
        ACCESS_HALF = 2'b01,
        ACCESS_WORD = 2'b10
    } data_access_t;

    // Wishbone master side of the bridge
    typedef enum logic {
        BRIDGE_IDLE  = 1'b0,                               // Waiting for re or we
        BRIDGE_CYCLE = 1'b1                                // cyc/stb out, waiting on ack
    } bridge_state_t;

endpackage

`default_nettype wire

//--- src/data_bus_if.sv
`default_nettype none

interface data_bus_if
    import mem_types_pkg::*;
();

    data_addr_t addr;       // Word aligned byte address
    logic       re;         // Read request
    logic       we;         // Write request
    byte_mask_t wb;         // Byte lanes to write
    data_t      wdata;      // Lane aligned store data
    data_t      rdata;      // Raw word from memory
    logic       busy;       // Request not yet finished

    // Adapter side
    modport master (
        output addr, re, we, wb, wdata,
        input  rdata, busy
    );

    // Memory side
    modport slave (
        input  addr, re, we, wb, wdata,
        output rdata, busy
    );

endinterface

`default_nettype wire

//--- src/data_mem_adapter.sv
`default_nettype none

module data_mem_adapter
    import mem_types_pkg::*;
(
    input  data_addr_t   i_addr,         // Byte address
    input  data_access_t i_access,       // Byte, half or word
    input  logic         i_unsigned,     // Zero extend loads
    input  logic         i_wr_en,        // Store request
    input  logic         i_rd_en,        // Load request
    input  data_t        i_wr_data,      // Low aligned store data
    output data_t        o_rd_data,      // Extended load result
    output logic         o_busy,         // Memory still working
    output logic         o_align_error,  // Misaligned half or word
    data_bus_if.master   bus             // Towards the bridge
);

    logic       [1:0] offset;
    logic             misaligned;
    logic             access_req;
    logic             wr_ok;
    byte_mask_t       lane_mask;
    data_t            lane_data;
    logic       [7:0] ld_byte;
    logic      [15:0] ld_half;

    assign offset     = i_addr[1:0];
    assign access_req = i_rd_en | i_wr_en;

    // Halves need an even offset, words a zero offset
    always_comb begin
        unique case (i_access)
            ACCESS_BYTE: misaligned = 1'b0;
            ACCESS_HALF: misaligned = offset[0];
            ACCESS_WORD: misaligned = (offset != 2'b00);
            default:     misaligned = 1'b1;             // Reserved size code
        endcase
    end

    assign o_align_error = access_req & misaligned;
    assign wr_ok         = i_wr_en & ~misaligned;

    // A misaligned request never reaches the bus
    assign bus.addr  = {i_addr[31:2], 2'b00};
    assign bus.re    = i_rd_en & ~misaligned;
    assign bus.we    = wr_ok;
    assign bus.wb    = wr_ok ? lane_mask : byte_mask_t'(0);
    assign bus.wdata = lane_data;

    assign o_busy = bus.busy;

    // Store side. The data is copied to every lane and the mask
    // picks which of them the RAM takes.
    always_comb begin
        lane_data = '0;
        lane_mask = '0;
        unique case (i_access)
            ACCESS_BYTE: begin
                lane_data = {4{i_wr_data[7:0]}};
                lane_mask = byte_mask_t'(4'b0001 << offset);
            end
            ACCESS_HALF: begin
                lane_data = {2{i_wr_data[15:0]}};
                lane_mask = offset[1] ? 4'b1100 : 4'b0011;
            end
            ACCESS_WORD: begin
                lane_data = i_wr_data;
                lane_mask = 4'b1111;
            end
            default: begin
                lane_data = '0;                         // Nothing written
                lane_mask = '0;
            end
        endcase
    end

    // Load side
    assign ld_byte = bus.rdata[{offset, 3'b000} +: 8];   // Lane chosen by offset
    assign ld_half = offset[1] ? bus.rdata[31:16] : bus.rdata[15:0];

    always_comb begin
        unique case (i_access)
            ACCESS_BYTE: o_rd_data = {{24{~i_unsigned & ld_byte[7]}}, ld_byte};
            ACCESS_HALF: o_rd_data = {{16{~i_unsigned & ld_half[15]}}, ld_half};
            ACCESS_WORD: o_rd_data = bus.rdata;
            default:     o_rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/wb_master_bridge.sv
`default_nettype none

module wb_master_bridge
    import mem_types_pkg::*;
(
    input  logic       i_clock,     // Clock
    input  logic       i_rst_n,     // Async active low reset
    data_bus_if.slave  bus,         // From the adapter
    output logic       o_wb_cyc,    // Wishbone cycle
    output logic       o_wb_stb,    // Wishbone strobe
    output logic       o_wb_we,     // Write cycle
    output data_addr_t o_wb_adr,    // Word address
    output byte_mask_t o_wb_sel,    // Byte selects
    output data_t      o_wb_dat,    // Write data
    input  data_t      i_wb_dat,    // Read data
    input  logic       i_wb_ack     // Cycle done
);

    bridge_state_t state;
    bridge_state_t state_next;
    logic          req;

    assign req = bus.re | bus.we;

    always_comb begin
        state_next = state;
        unique case (state)
            BRIDGE_IDLE: begin
                if (req) begin
                    state_next = BRIDGE_CYCLE;
                end
            end
            BRIDGE_CYCLE: begin
                if (i_wb_ack) begin
                    state_next = BRIDGE_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= BRIDGE_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Classic single cycle with cyc and stb straight from the state
    assign o_wb_cyc = (state == BRIDGE_CYCLE);
    assign o_wb_stb = (state == BRIDGE_CYCLE);

    // The adapter holds the request, so the bus fields pass through
    assign o_wb_we  = bus.we;
    assign o_wb_adr = {2'b00, bus.addr[31:2]};
    assign o_wb_sel = bus.we ? bus.wb : byte_mask_t'('1);  // Reads take the full word
    assign o_wb_dat = bus.wdata;

    assign bus.rdata = i_wb_dat;
    assign bus.busy  = req & ~(o_wb_cyc & i_wb_ack);     // Drops in the ack cycle

    // The RAM must only answer a cycle we started
    a_ack_in_cycle : assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        i_wb_ack |-> (state == BRIDGE_CYCLE)
    );

    // Adapter side keeps its request steady until busy drops
    a_req_stable : assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        (state == BRIDGE_CYCLE) |-> ($stable(bus.addr) && $stable(bus.re) &&
                                     $stable(bus.we) && $stable(bus.wb) &&
                                     $stable(bus.wdata))
    );

endmodule

`default_nettype wire

//--- src/wb_data_ram.sv
`default_nettype none

module wb_data_ram
    import mem_types_pkg::*;
(
    input  logic       i_clock,     // Clock
    input  logic       i_rst_n,     // Async active low reset
    input  logic       i_wb_cyc,    // Wishbone cycle
    input  logic       i_wb_stb,    // Wishbone strobe
    input  logic       i_wb_we,     // Write cycle
    input  data_addr_t i_wb_adr,    // Word address
    input  byte_mask_t i_wb_sel,    // Byte selects
    input  data_t      i_wb_dat,    // Write data
    output data_t      o_wb_dat,    // Registered read data
    output logic       o_wb_ack     // One cycle acknowledge
);

    data_t                  mem [DATA_MEM_WORDS];
    logic [DATA_MEM_AW-1:0] word_idx;
    logic                   access;

    assign word_idx = i_wb_adr[DATA_MEM_AW-1:0];   // Upper bits ignored so addresses wrap

    // The ack itself blocks a second take of the same cycle
    assign access = i_wb_cyc & i_wb_stb & ~o_wb_ack;

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= access;
        end
    end

    always_ff @(posedge i_clock) begin
        if (access) begin
            if (i_wb_we) begin
                for (int lane = 0; lane < DATA_LANES; lane++) begin
                    if (i_wb_sel[lane]) begin
                        mem[word_idx][lane*8 +: 8] <= i_wb_dat[lane*8 +: 8];
                    end
                end
            end
            o_wb_dat <= mem[word_idx];              // Old word on a write
        end
    end

endmodule

`default_nettype wire

//--- src/data_mem_subsys.sv
`default_nettype none

module data_mem_subsys
    import mem_types_pkg::*;
(
    input  logic         i_clock,        // Clock
    input  logic         i_rst_n,        // Async reset, active low
    input  data_addr_t   i_addr,         // Byte address
    input  data_access_t i_access,       // Byte, half or word
    input  logic         i_unsigned,     // Zero extend loads
    input  logic         i_wr_en,        // Store request
    input  logic         i_rd_en,        // Load request
    input  data_t        i_wr_data,      // Store data
    output data_t        o_rd_data,      // Load result
    output logic         o_busy,         // Hold the request while high
    output logic         o_align_error   // Misaligned access, not issued
);

    data_bus_if u_bus ();

    // Wishbone classic between bridge and RAM
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    logic       wb_ack;
    data_addr_t wb_adr;
    byte_mask_t wb_sel;
    data_t      wb_dat_w;
    data_t      wb_dat_r;

    data_mem_adapter u_adapter (
        .i_addr        (i_addr),
        .i_access      (i_access),
        .i_unsigned    (i_unsigned),
        .i_wr_en       (i_wr_en),
        .i_rd_en       (i_rd_en),
        .i_wr_data     (i_wr_data),
        .o_rd_data     (o_rd_data),
        .o_busy        (o_busy),
        .o_align_error (o_align_error),
        .bus           (u_bus.master)
    );

    wb_master_bridge u_bridge (
        .i_clock  (i_clock),
        .i_rst_n  (i_rst_n),
        .bus      (u_bus.slave),
        .o_wb_cyc (wb_cyc),
        .o_wb_stb (wb_stb),
        .o_wb_we  (wb_we),
        .o_wb_adr (wb_adr),
        .o_wb_sel (wb_sel),
        .o_wb_dat (wb_dat_w),
        .i_wb_dat (wb_dat_r),
        .i_wb_ack (wb_ack)
    );

    wb_data_ram u_ram (
        .i_clock  (i_clock),
        .i_rst_n  (i_rst_n),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_we  (wb_we),
        .i_wb_adr (wb_adr),
        .i_wb_sel (wb_sel),
        .i_wb_dat (wb_dat_w),
        .o_wb_dat (wb_dat_r),
        .o_wb_ack (wb_ack)
    );

endmodule

`default_nettype wire

//--- testbench/tb_data_mem_subsys.sv
`default_nettype none

module tb_data_mem_subsys
    import mem_types_pkg::*;
();

    localparam int WAIT_LIMIT = 16;                 // Cycles allowed per request

    logic         clock;
    logic         rst_n;
    data_addr_t   addr;
    data_access_t access;
    logic         unsigned_ld;
    logic         wr_en;
    logic         rd_en;
    data_t        wr_data;
    data_t        rd_data;
    logic         busy;
    logic         align_error;

    logic [7:0]  model [DATA_MEM_WORDS][4];         // Expected RAM bytes, word by lane
    logic [15:0] lfsr_state;
    int          checks;
    int          errors;
    int          timeouts;

    data_mem_subsys u_dut (
        .i_clock       (clock),
        .i_rst_n       (rst_n),
        .i_addr        (addr),
        .i_access      (access),
        .i_unsigned    (unsigned_ld),
        .i_wr_en       (wr_en),
        .i_rd_en       (rd_en),
        .i_wr_data     (wr_data),
        .o_rd_data     (rd_data),
        .o_busy        (busy),
        .o_align_error (align_error)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #2 clock = ~clock;
        end
    end

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic data_t rand_bits(input int count);
        data_t value;
        logic  fb;
        value = '0;
        for (int i = 0; i < count; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            value      = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic logic is_misaligned(input data_addr_t a, input data_access_t size);
        case (size)
            ACCESS_HALF: return a[0];
            ACCESS_WORD: return (a[1:0] != 2'b00);
            default:     return 1'b0;
        endcase
    endfunction

    // Little endian lanes, bits above the RAM window are dropped
    function automatic data_t expected_load(input data_addr_t a, input data_access_t size,
                                            input logic uns);
        logic [DATA_MEM_AW-1:0] w;
        logic [7:0]             b;
        logic [15:0]            h;
        w = a[DATA_MEM_AW+1:2];
        b = model[w][a[1:0]];
        h = {model[w][{a[1], 1'b1}], model[w][{a[1], 1'b0}]};
        case (size)
            ACCESS_BYTE: return uns ? {24'h0, b} : {{24{b[7]}}, b};
            ACCESS_HALF: return uns ? {16'h0, h} : {{16{h[15]}}, h};
            default:     return {model[w][2'd3], model[w][2'd2], model[w][2'd1], model[w][2'd0]};
        endcase
    endfunction

    task automatic model_store(input data_addr_t a, input data_access_t size, input data_t d);
        logic [DATA_MEM_AW-1:0] w;
        w = a[DATA_MEM_AW+1:2];
        case (size)
            ACCESS_BYTE: model[w][a[1:0]] = d[7:0];
            ACCESS_HALF: begin
                model[w][{a[1], 1'b0}] = d[7:0];
                model[w][{a[1], 1'b1}] = d[15:8];
            end
            default: begin
                model[w][2'd0] = d[7:0];
                model[w][2'd1] = d[15:8];
                model[w][2'd2] = d[23:16];
                model[w][2'd3] = d[31:24];
            end
        endcase
    endtask

    task automatic check_value(input string name, input data_t got, input data_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR at %0t: %s expected %b, got %b", $time, name, exp, got);
        end
    endtask

    // Polls mid cycle, where the outputs have settled
    task automatic wait_not_busy(output logic done);
        int cycles;
        cycles = 0;
        while (busy && cycles < WAIT_LIMIT) begin
            @(posedge clock);
            #2;
            cycles++;
        end
        done = !busy;
        if (!done) begin
            timeouts++;
            $display("Timeout at %0t: o_busy still high after %0d cycles", $time, WAIT_LIMIT);
        end
    endtask

    // One request, held until the cycle after busy drops
    task automatic do_access(input data_addr_t a, input data_access_t size, input logic uns,
                             input logic write, input data_t d);
        logic  bad;
        logic  done;
        data_t expected;
        bad      = is_misaligned(a, size);
        expected = expected_load(a, size, uns);
        @(posedge clock);
        #1;
        addr        = a;
        access      = size;
        unsigned_ld = uns;
        wr_en       = write;
        rd_en       = !write;
        wr_data     = d;
        #1;
        check_bit("o_align_error", align_error, bad);
        check_bit("o_busy", busy, !bad);         // Aligned requests start a bus cycle
        if (!bad) begin
            wait_not_busy(done);
            if (done && !write) begin
                check_value("o_rd_data", rd_data, expected);
            end
            if (done && write) begin
                model_store(a, size, d);
            end
        end
        @(posedge clock);
        #1;
        wr_en = 1'b0;
        rd_en = 1'b0;
    endtask

    task automatic reset_dut();
        rst_n       = 1'b0;
        addr        = '0;
        access      = ACCESS_WORD;
        unsigned_ld = 1'b0;
        wr_en       = 1'b0;
        rd_en       = 1'b0;
        wr_data     = '0;
        repeat (5) @(posedge clock);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic fill_memory();
        data_t pattern;
        for (int w = 0; w < DATA_MEM_WORDS; w++) begin
            pattern = {8'hC3, w[7:0], ~w[7:0], w[7:0] ^ 8'h5A};
            do_access(data_addr_t'(w) << 2, ACCESS_WORD, 1'b0, 1'b1, pattern);
        end
    endtask

    task automatic test_reset_and_word();
        @(posedge clock);
        #2;
        check_bit("o_busy", busy, 1'b0);
        check_bit("o_align_error", align_error, 1'b0);
        do_access(32'h0000_0040, ACCESS_WORD, 1'b0, 1'b1, 32'hDEAD_BEEF);
        do_access(32'h0000_0040, ACCESS_WORD, 1'b0, 1'b0, '0);
    endtask

    task automatic test_lane_merge();
        for (int off = 0; off < 4; off++) begin
            // Upper bits of the store data must be ignored
            do_access(32'h80 + data_addr_t'(off), ACCESS_BYTE, 1'b0, 1'b1,
                      32'h5500_00C0 + data_t'(off));
        end
        do_access(32'h80, ACCESS_WORD, 1'b0, 1'b0, '0);
        do_access(32'h90, ACCESS_HALF, 1'b0, 1'b1, 32'hFFFF_1234);
        do_access(32'h92, ACCESS_HALF, 1'b0, 1'b1, 32'h0000_ABCD);
        do_access(32'h90, ACCESS_WORD, 1'b0, 1'b0, '0);
    endtask

    task automatic test_load_extension();
        do_access(32'hA0, ACCESS_WORD, 1'b0, 1'b1, 32'h7F80_01FE);   // Mixed sign bytes
        do_access(32'hA4, ACCESS_WORD, 1'b0, 1'b1, 32'h8001_7FFF);   // One negative half
        for (int u = 0; u < 2; u++) begin
            for (int off = 0; off < 4; off++) begin
                do_access(32'hA0 + data_addr_t'(off), ACCESS_BYTE, u[0], 1'b0, '0);
            end
            for (int off = 0; off < 8; off += 2) begin
                do_access(32'hA0 + data_addr_t'(off), ACCESS_HALF, u[0], 1'b0, '0);
            end
        end
    endtask

    task automatic test_misaligned();
        do_access(32'hC0, ACCESS_WORD, 1'b0, 1'b1, 32'h1357_9BDF);
        for (int off = 1; off < 4; off += 2) begin
            do_access(32'hC0 + data_addr_t'(off), ACCESS_HALF, 1'b0, 1'b0, '0);
            do_access(32'hC0 + data_addr_t'(off), ACCESS_HALF, 1'b0, 1'b1, 32'hFFFF_FFFF);
        end
        for (int off = 1; off < 4; off++) begin
            do_access(32'hC0 + data_addr_t'(off), ACCESS_WORD, 1'b0, 1'b0, '0);
            do_access(32'hC0 + data_addr_t'(off), ACCESS_WORD, 1'b0, 1'b1, 32'h0BAD_0BAD);
        end
        do_access(32'hC0, ACCESS_WORD, 1'b0, 1'b0, '0);       // Still the first word
        do_access(32'hC4, ACCESS_WORD, 1'b0, 1'b0, '0);       // Neighbour untouched too
    endtask

    task automatic test_random(input int count);
        data_t        hi;
        data_t        lo;
        data_t        pick;
        data_t        d;
        data_access_t size;
        logic         uns;
        logic         write;
        for (int n = 0; n < count; n++) begin
            hi    = rand_bits(4);
            lo    = rand_bits(12);                  // Up to 4 KiB, past the RAM window
            pick  = rand_bits(2);
            size  = (pick[1:0] == 2'b11) ? ACCESS_BYTE : data_access_t'(pick[1:0]);
            pick  = rand_bits(1);
            uns   = pick[0];
            pick  = rand_bits(1);
            write = pick[0];
            d     = rand_bits(32);
            do_access({hi[3:0], 16'h0000, lo[11:0]}, size, uns, write, d);
        end
    endtask

    initial begin
        checks     = 0;
        errors     = 0;
        timeouts   = 0;
        lfsr_state = 16'd31086;
        reset_dut();
        test_reset_and_word();
        fill_memory();                              // Every later read hits known data
        test_lane_merge();
        test_load_extension();
        test_misaligned();
        test_random(200);
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
src/mem_types_pkg.sv
src/data_bus_if.sv
src/data_mem_adapter.sv
src/wb_master_bridge.sv
src/wb_data_ram.sv
src/data_mem_subsys.sv
testbench/tb_data_mem_subsys.sv

//--- Makefile
TOP = tb_data_mem_subsys

.PHONY: sim clean

sim:
	verilator --binary --assert --top-module $(TOP) -f list.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
